//--- flist.f
+incdir+include
verilog/hazard_pkg.sv
verilog/operandDecode.sv
verilog/stallDetect.sv
verilog/forwardSelect.sv
verilog/issueStage.sv
verilog/hazardUnit.sv
verif/hazardUnitTb.sv

//--- include/hazard_consts.svh
// hazard unit constants
// instruction field widths, opcode encodings and writeback-select codes
`ifndef HAZARD_CONSTS_SVH
`define HAZARD_CONSTS_SVH

// instruction word and field widths
`define HAZ_INSTR_W   16
`define HAZ_REG_W     3
`define HAZ_OPC_W     5

// opcodes the hazard unit decodes by name
`define HAZ_OPC_HALT  5'b00000
`define HAZ_OPC_NOP   5'b00001
`define HAZ_OPC_SIIC  5'b00010
`define HAZ_OPC_RTI   5'b00011
`define HAZ_OPC_ST    5'b10000
`define HAZ_OPC_STU   5'b10011
`define HAZ_OPC_LBI   5'b11000
`define HAZ_OPC_BITOP 5'b11010
`define HAZ_OPC_ARITH 5'b11011

// bubble issued in place of a stalled instruction
`define HAZ_NOP_WORD  16'h0800

// writeback source select, as carried by each downstream stage
`define HAZ_WB_PC     2'b00
`define HAZ_WB_MEM    2'b01
`define HAZ_WB_ALU    2'b10
`define HAZ_WB_IMM    2'b11

`endif

//--- verif/hazardUnitTb.sv
// hazard unit testbench
// directed and random stimulus, checked against a model by concurrent assertions
`timescale 1ns/100ps

`include "hazard_consts.svh"

module hazardUnitTb import hazard_pkg::*; ();

    // everything the issue register shows in one cycle
    typedef struct packed {
        instrWord_u instr;
        logic       pcNop;
        fwdCtrl_t   fwA;
        fwdCtrl_t   fwB;
    } issueOut_t;

    logic         clk = 1'b0;
    logic         rstN;
    instrWord_u   fetchInstr;
    stageStatus_t stageD;
    stageStatus_t stageX;
    stageStatus_t stageM;
    stageStatus_t stageW;
    instrWord_u   issuedInstr;
    logic         pcNop;
    fwdCtrl_t     fwCntrlA;
    fwdCtrl_t     fwCntrlB;

    issueOut_t    expQ;
    string        testName;
    string        checkName;
    int           errors;
    integer       seed;

    hazardUnit u_hazardUnit (
        .clk         (clk),
        .rstN        (rstN),
        .fetchInstr  (fetchInstr),
        .stageD      (stageD),
        .stageX      (stageX),
        .stageM      (stageM),
        .stageW      (stageW),
        .issuedInstr (issuedInstr),
        .pcNop       (pcNop),
        .fwCntrlA    (fwCntrlA),
        .fwCntrlB    (fwCntrlB)
    );

    always #20 clk = ~clk;

    function automatic instrWord_u encodeInstr(input logic [4:0] opc, input logic [2:0] rs,
                                               input logic [2:0] r2);
        return instrWord_u'({opc, rs, r2, 5'b0});
    endfunction

    function automatic stageStatus_t packStage(input logic wrt, input logic [2:0] r,
                                               input logic [1:0] sel, input logic br);
        return stageStatus_t'({wrt, r, sel, br});
    endfunction

    function automatic logic writesReg(input stageStatus_t s, input logic [2:0] r);
        return s.regWrt && s.wrtReg == r;
    endfunction

    // operand use, straight from the opcode table
    function automatic operandUse_t decodeUse(input logic [4:0] opc);
        operandUse_t u;
        u = '0;
        if (opc == `HAZ_OPC_ST || opc == `HAZ_OPC_STU) begin
            u.readsA  = 1'b1;
            u.readsB  = 1'b1;
            u.isStore = 1'b1;
        end else if (opc == `HAZ_OPC_ARITH || opc == `HAZ_OPC_BITOP || opc[4:2] == 3'b111) begin
            u.readsA = 1'b1;
            u.readsB = 1'b1;
        end else if (opc == `HAZ_OPC_SIIC || opc == `HAZ_OPC_RTI) begin
            u.passThrough = 1'b1;
        end else if (!(opc == `HAZ_OPC_LBI || opc == `HAZ_OPC_HALT || opc == `HAZ_OPC_NOP ||
                       opc == 5'b00100 || opc == 5'b00110)) begin
            // branches, jr/jalr and the rest read rs only
            u.readsA = 1'b1;
        end
        return u;
    endfunction

    function automatic fwdCtrl_t expectFwd(input logic reads, input logic [2:0] r,
                                           input stageStatus_t d, input stageStatus_t x);
        fwdCtrl_t f;
        logic     dLoad;
        f     = '0;
        // a pending load in decode blocks every forward of r
        dLoad = writesReg(d, r) && d.wbDataSel == `HAZ_WB_MEM;
        if (reads) begin
            f.fwdEn   = (writesReg(d, r) || writesReg(x, r)) && !dLoad;
            f.fromMem = !writesReg(d, r);
            f.src     = writesReg(d, r) ? d.wbDataSel : x.wbDataSel;
        end
        return f;
    endfunction

    function automatic issueOut_t predictIssue(input instrWord_u w, input stageStatus_t d,
                                               input stageStatus_t x, input stageStatus_t m,
                                               input stageStatus_t wb);
        issueOut_t   o;
        operandUse_t u;
        logic [2:0]  rA;
        logic [2:0]  rB;
        logic        blockA;
        logic        blockB;
        u  = decodeUse(w.aluView.opc);
        rA = w.aluView.rs;
        rB = u.isStore ? w.storeView.rd : w.aluView.rt;
        blockA = u.readsA && ((writesReg(m, rA) && !writesReg(x, rA)) ||
                 (writesReg(d, rA) && d.wbDataSel == `HAZ_WB_MEM));
        blockB = u.readsB && ((writesReg(m, rB) && !writesReg(x, rB)) ||
                 (writesReg(d, rB) && d.wbDataSel == `HAZ_WB_MEM));
        o.pcNop = !u.passThrough && (blockA || blockB || d.branchInst || x.branchInst ||
                  m.branchInst || wb.branchInst);
        o.instr = o.pcNop ? instrWord_u'(`HAZ_NOP_WORD) : w;
        o.fwA   = expectFwd(u.readsA, rA, d, x);
        o.fwB   = expectFwd(u.readsB, rB, d, x);
        o.fwB.stuSel = u.isStore;
        return o;
    endfunction

    // model register lags the inputs by one cycle like the issue stage
    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            expQ.instr <= `HAZ_NOP_WORD;
            expQ.pcNop <= 1'b0;
            expQ.fwA   <= '0;
            expQ.fwB   <= '0;
        end else begin
            expQ <= predictIssue(fetchInstr, stageD, stageX, stageM, stageW);
        end
        checkName <= testName;
    end

    // outputs only move on the rising edge, so check them on the falling one
    instrCheck: assert property (@(negedge clk) issuedInstr == expQ.instr)
        else begin
            errors++;
            $display("error %s issuedInstr expected %h actual %h",
                     checkName, expQ.instr, issuedInstr);
        end
    pcNopCheck: assert property (@(negedge clk) pcNop == expQ.pcNop)
        else begin
            errors++;
            $display("error %s pcNop expected %b actual %b", checkName, expQ.pcNop, pcNop);
        end
    fwdACheck: assert property (@(negedge clk) fwCntrlA == expQ.fwA)
        else begin
            errors++;
            $display("error %s fwCntrlA expected %b actual %b", checkName, expQ.fwA, fwCntrlA);
        end
    fwdBCheck: assert property (@(negedge clk) fwCntrlB == expQ.fwB)
        else begin
            errors++;
            $display("error %s fwCntrlB expected %b actual %b", checkName, expQ.fwB, fwCntrlB);
        end

    task automatic finishRun();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    task automatic drive(input string name, input instrWord_u w, input stageStatus_t d,
                         input stageStatus_t x, input stageStatus_t m, input stageStatus_t wb);
        @(negedge clk);
        testName   = name;
        fetchInstr = w;
        stageD     = d;
        stageX     = x;
        stageM     = m;
        stageW     = wb;
    endtask

    task automatic waitForPcNop(input int maxCycles);
        int n;
        n = 0;
        while (pcNop !== 1'b1 && n < maxCycles) begin
            @(negedge clk);
            n++;
        end
        if (pcNop !== 1'b1) begin
            errors++;
            $display("timeout: pcNop never rose during %s", testName);
            finishRun();
        end
    endtask

    initial begin
        stageStatus_t idle;
        stageStatus_t br;
        instrWord_u   w;
        idle       = '0;
        errors     = 0;
        seed       = 23;
        rstN       = 1'b0;
        testName   = "reset";
        fetchInstr = encodeInstr(`HAZ_OPC_ARITH, 3'd1, 3'd2);
        stageD     = idle;
        stageX     = idle;
        stageM     = idle;
        stageW     = idle;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        // load in decode feeding rs of the next alu op
        drive("load use", encodeInstr(`HAZ_OPC_ARITH, 3'd3, 3'd1),
              packStage(1'b1, 3'd3, `HAZ_WB_MEM, 1'b0), idle, idle, idle);
        waitForPcNop(4);
        drive("load use rt", encodeInstr(`HAZ_OPC_BITOP, 3'd0, 3'd6),
              packStage(1'b1, 3'd6, `HAZ_WB_MEM, 1'b0), idle, idle, idle);

        drive("forward from x", encodeInstr(`HAZ_OPC_ARITH, 3'd2, 3'd5), idle,
              packStage(1'b1, 3'd2, `HAZ_WB_ALU, 1'b0), idle, idle);
        drive("forward from d", encodeInstr(5'b11101, 3'd0, 3'd5),
              packStage(1'b1, 3'd5, `HAZ_WB_IMM, 1'b0),
              packStage(1'b1, 3'd5, `HAZ_WB_PC, 1'b0), idle, idle);
        drive("m write masked by x", encodeInstr(`HAZ_OPC_ARITH, 3'd4, 3'd4), idle,
              packStage(1'b1, 3'd4, `HAZ_WB_ALU, 1'b0),
              packStage(1'b1, 3'd4, `HAZ_WB_MEM, 1'b0), idle);

        // data register travels in the rd field
        drive("store st", encodeInstr(`HAZ_OPC_ST, 3'd1, 3'd4), idle,
              packStage(1'b1, 3'd4, `HAZ_WB_ALU, 1'b0), idle, idle);
        drive("store stu", encodeInstr(`HAZ_OPC_STU, 3'd7, 3'd4),
              packStage(1'b1, 3'd4, `HAZ_WB_IMM, 1'b0), idle, idle, idle);

        for (int s = 0; s < 4; s++) begin
            for (int k = 0; k < 3; k++) begin
                br = packStage(1'b0, 3'd0, `HAZ_WB_PC, 1'b1);
                w  = (k == 0) ? encodeInstr(`HAZ_OPC_LBI, 3'd2, 3'd0) :
                     (k == 1) ? encodeInstr(5'b00100, 3'd0, 3'd0) :
                                encodeInstr(`HAZ_OPC_ARITH, 3'd1, 3'd2);
                drive("branch in flight", w, (s == 0) ? br : idle, (s == 1) ? br : idle,
                      (s == 2) ? br : idle, (s == 3) ? br : idle);
            end
        end

        // siic and rti issue even with every hazard present
        br = packStage(1'b1, 3'd0, `HAZ_WB_MEM, 1'b1);
        drive("pass through siic", encodeInstr(`HAZ_OPC_SIIC, 3'd0, 3'd0), br, br, br, br);
        drive("pass through rti", encodeInstr(`HAZ_OPC_RTI, 3'd0, 3'd0), br, br, br, br);

        for (int i = 0; i < 300; i++) begin
            drive("random", instrWord_u'($random(seed)),
                  packStage($random(seed), $random(seed), $random(seed), ($random(seed) & 7) == 0),
                  packStage($random(seed), $random(seed), $random(seed), ($random(seed) & 7) == 0),
                  packStage($random(seed), $random(seed), $random(seed), ($random(seed) & 7) == 0),
                  packStage($random(seed), $random(seed), $random(seed), ($random(seed) & 7) == 0));
        end

        drive("flush", encodeInstr(`HAZ_OPC_NOP, 3'd0, 3'd0), idle, idle, idle, idle);
        @(negedge clk);
        @(posedge clk);
        finishRun();
    end

endmodule

//--- verilog/forwardSelect.sv
// forward select
// builds the execute-stage forward control word for operands a and b
`timescale 1ns/100ps

`include "hazard_consts.svh"

module forwardSelect import hazard_pkg::*; (
    input  instrWord_u   fetchInstr,
    input  operandUse_t  useInfo,
    input  stageStatus_t stageD,
    input  stageStatus_t stageX,
    output fwdCtrl_t     fwdA,
    output fwdCtrl_t     fwdB
);

    logic [`HAZ_REG_W-1:0] regA;
    logic [`HAZ_REG_W-1:0] regB;

    // forward word for one operand, zero when the operand is unused
    function automatic fwdCtrl_t buildFwd(
        input logic                  reads,
        input logic [`HAZ_REG_W-1:0] r,
        input stageStatus_t          d,
        input stageStatus_t          x
    );
        fwdCtrl_t f;
        logic     dHit;
        logic     xHit;
        logic     dLoad;
        f     = '0;
        dHit  = d.regWrt && (d.wrtReg == r);
        xHit  = x.regWrt && (x.wrtReg == r);
        dLoad = d.wbDataSel == `HAZ_WB_MEM;
        if (reads) begin
            // nearest writer wins and a load in decode is never forwardable
            f.fwdEn   = (dHit && !dLoad) || (xHit && !(dHit && dLoad));
            // decode's result goes ex to ex, otherwise it comes from mem
            f.fromMem = !dHit;
            f.src     = f.fromMem ? x.wbDataSel : d.wbDataSel;
        end
        return f;
    endfunction

    assign regA = fetchInstr.aluView.rs;
    // rd of a store and rt of an alu op sit in the same bits
    assign regB = fetchInstr.aluView.rt;

    always_comb begin
        fwdA = buildFwd(useInfo.readsA, regA, stageD, stageX);
        fwdB = buildFwd(useInfo.readsB, regB, stageD, stageX);
        // store data rides on operand b
        fwdB.stuSel = useInfo.isStore;
    end

endmodule

//--- verilog/hazardUnit.sv
// hazard unit top
// operand decode, stall and forward evaluation, then the issue register
`timescale 1ns/100ps

module hazardUnit import hazard_pkg::*; (
    input  logic         clk,
    input  logic         rstN,
    input  instrWord_u   fetchInstr,
    input  stageStatus_t stageD,
    input  stageStatus_t stageX,
    input  stageStatus_t stageM,
    input  stageStatus_t stageW,
    output instrWord_u   issuedInstr,
    output logic         pcNop,
    output fwdCtrl_t     fwCntrlA,
    output fwdCtrl_t     fwCntrlB
);

    operandUse_t useInfo;
    logic        stall;
    fwdCtrl_t    fwdA;
    fwdCtrl_t    fwdB;

    // which operands the fetched word reads
    operandDecode u_operandDecode (
        .fetchInstr (fetchInstr),
        .useInfo    (useInfo)
    );

    // raw hazards past forwarding reach, plus branches in flight
    stallDetect u_stallDetect (
        .fetchInstr (fetchInstr),
        .useInfo    (useInfo),
        .stageD     (stageD),
        .stageX     (stageX),
        .stageM     (stageM),
        .stageW     (stageW),
        .stall      (stall)
    );

    // only decode and execute feed forward paths
    forwardSelect u_forwardSelect (
        .fetchInstr (fetchInstr),
        .useInfo    (useInfo),
        .stageD     (stageD),
        .stageX     (stageX),
        .fwdA       (fwdA),
        .fwdB       (fwdB)
    );

    issueStage u_issueStage (
        .clk         (clk),
        .rstN        (rstN),
        .fetchInstr  (fetchInstr),
        .stall       (stall),
        .fwdA        (fwdA),
        .fwdB        (fwdB),
        .issuedInstr (issuedInstr),
        .pcNop       (pcNop),
        .fwCntrlA    (fwCntrlA),
        .fwCntrlB    (fwCntrlB)
    );

endmodule

//--- verilog/hazard_pkg.sv
// hazard unit types
// instruction views, downstream stage status and forward-control words
package hazard_pkg;

`include "hazard_consts.svh"

    // bits left below the two register fields
    localparam int LowW = `HAZ_INSTR_W - `HAZ_OPC_W - 2 * `HAZ_REG_W;

    // store format: second register field is the data source rd
    typedef struct packed {
        logic [`HAZ_OPC_W-1:0] opc;
        logic [`HAZ_REG_W-1:0] rs;
        logic [`HAZ_REG_W-1:0] rd;
        logic [LowW-1:0]       low;
    } storeView_t;

    // alu format: same bits, second field is source operand rt
    typedef struct packed {
        logic [`HAZ_OPC_W-1:0] opc;
        logic [`HAZ_REG_W-1:0] rs;
        logic [`HAZ_REG_W-1:0] rt;
        logic [LowW-1:0]       low;
    } aluView_t;

    // one fetched word, read through whichever view the opcode implies
    typedef union packed {
        storeView_t storeView;
        aluView_t   aluView;
    } instrWord_u;

    // status of one stage downstream of fetch
    typedef struct packed {
        logic                  regWrt;
        logic [`HAZ_REG_W-1:0] wrtReg;
        logic [1:0]            wbDataSel;
        logic                  branchInst;
    } stageStatus_t;

    // which operands the fetched instruction reads
    typedef struct packed {
        logic readsA;
        logic readsB;
        logic isStore;
        logic passThrough;
    } operandUse_t;

    // forward control for one execute operand, msb first as on the bus
    typedef struct packed {
        logic       stuSel;
        logic       fwdEn;
        logic       fromMem;
        logic [1:0] src;
    } fwdCtrl_t;

endpackage

//--- verilog/issueStage.sv
// issue stage
// fetch/decode pipeline register, drops in a nop bubble on a stall
`timescale 1ns/100ps

`include "hazard_consts.svh"

module issueStage import hazard_pkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  instrWord_u fetchInstr,
    input  logic       stall,
    input  fwdCtrl_t   fwdA,
    input  fwdCtrl_t   fwdB,
    output instrWord_u issuedInstr,
    output logic       pcNop,
    output fwdCtrl_t   fwCntrlA,
    output fwdCtrl_t   fwCntrlB
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            // come out of reset issuing bubbles with no forwarding
            issuedInstr <= `HAZ_NOP_WORD;
            pcNop       <= 1'b0;
            fwCntrlA    <= '0;
            fwCntrlB    <= '0;
        end else begin
            if (stall) begin
                issuedInstr <= `HAZ_NOP_WORD;
            end else begin
                issuedInstr <= fetchInstr;
            end
            // pcNop holds the pc so the stalled word is fetched again
            pcNop    <= stall;
            fwCntrlA <= fwdA;
            fwCntrlB <= fwdB;
        end
    end

endmodule

//--- verilog/operandDecode.sv
// operand decode
// sorts the fetched opcode by the register operands it reads
`timescale 1ns/100ps

`include "hazard_consts.svh"

module operandDecode import hazard_pkg::*; (
    input  instrWord_u  fetchInstr,
    output operandUse_t useInfo
);

    // opcode sits in the same place in both views
    logic [`HAZ_OPC_W-1:0] opc;

    assign opc = fetchInstr.aluView.opc;

    always_comb begin
        // default covers branches, jr/jalr and the immediate forms
        useInfo = '0;
        useInfo.readsA = 1'b1;

        casez (opc)
            // stores read base rs and data rd
            `HAZ_OPC_ST,
            `HAZ_OPC_STU: begin
                useInfo.readsB  = 1'b1;
                useInfo.isStore = 1'b1;
            end

            // two-source alu ops
            `HAZ_OPC_ARITH,
            `HAZ_OPC_BITOP,
            5'b111??: begin
                useInfo.readsB = 1'b1;
            end

            // no register source at all
            `HAZ_OPC_LBI,
            `HAZ_OPC_HALT,
            `HAZ_OPC_NOP: begin
                useInfo.readsA = 1'b0;
            end

            // j and jal, pure control
            5'b001?0: begin
                useInfo.readsA = 1'b0;
            end

            // siic and rti go through untouched, never stalled
            `HAZ_OPC_SIIC,
            `HAZ_OPC_RTI: begin
                useInfo.readsA      = 1'b0;
                useInfo.passThrough = 1'b1;
            end

            // branches 011xx and jr/jalr 001x1 land here, rs only
            default: begin
                useInfo.readsA = 1'b1;
            end
        endcase
    end

endmodule

//--- verilog/stallDetect.sv
// stall detect
// flags reads that forwarding cannot serve and branches still in flight
`timescale 1ns/100ps

`include "hazard_consts.svh"

module stallDetect import hazard_pkg::*; (
    input  instrWord_u   fetchInstr,
    input  operandUse_t  useInfo,
    input  stageStatus_t stageD,
    input  stageStatus_t stageX,
    input  stageStatus_t stageM,
    input  stageStatus_t stageW,
    output logic         stall
);

    logic [`HAZ_REG_W-1:0] regA;
    logic [`HAZ_REG_W-1:0] regB;
    logic                  blockedA;
    logic                  blockedB;
    logic                  branchBusy;

    // true when register r cannot be supplied by any forward path
    function automatic logic operandBlocked(
        input logic [`HAZ_REG_W-1:0] r,
        input stageStatus_t          d,
        input stageStatus_t          x,
        input stageStatus_t          m
    );
        logic dHit;
        logic xHit;
        logic mHit;
        dHit = d.regWrt && (d.wrtReg == r);
        xHit = x.regWrt && (x.wrtReg == r);
        mHit = m.regWrt && (m.wrtReg == r);
        // mem result is too late for ex unless ex overwrites it anyway
        // load in decode has no data until after mem
        return (mHit && !xHit) || (dHit && (d.wbDataSel == `HAZ_WB_MEM));
    endfunction

    assign regA = fetchInstr.aluView.rs;
    // rd of a store and rt of an alu op sit in the same bits
    assign regB = fetchInstr.aluView.rt;

    assign blockedA = useInfo.readsA && operandBlocked(regA, stageD, stageX, stageM);
    assign blockedB = useInfo.readsB && operandBlocked(regB, stageD, stageX, stageM);

    // hold issue while any branch or jump has not resolved
    assign branchBusy = stageD.branchInst | stageX.branchInst |
                        stageM.branchInst | stageW.branchInst;

    assign stall = !useInfo.passThrough && (blockedA || blockedB || branchBusy);

endmodule
